//--- hw/microrocPkg.sv
package microrocPkg;

    ////////////////////////////////////////////////////////////
    // Chain and parameter image sizes
    ////////////////////////////////////////////////////////////

    localparam int ChainCountDefault = 4;
    localparam int ParamWidth = 48;

    // Reduced MICROROC slow-control image shifted out MSB first
    typedef struct packed {
        logic [9:0] dac2Vth;
        logic [9:0] dac1Vth;
        logic [9:0] dac0Vth;
        logic [7:0] chipId;
        logic [2:0] triggerToWriteSelect;
        logic [1:0] internalRazLength;
        logic       dacEnable;
        logic       bandGapEnable;
        logic       otaqEnable;
        logic       gainBoostEnable;
        logic       externalTriggerEnable;
    } microrocParamT;

    ////////////////////////////////////////////////////////////
    // AXI4-Lite
    ////////////////////////////////////////////////////////////

    localparam int AxiAddrWidth = 4;
    localparam int AxiDataWidth = 32;
    localparam logic [1:0] RespOkay = 2'b00;

    typedef struct packed {
        logic                        awvalid;
        logic [AxiAddrWidth-1:0]     awaddr;
        logic                        wvalid;
        logic [AxiDataWidth-1:0]     wdata;
        logic [AxiDataWidth/8-1:0]   wstrb;
        logic                        bready;
        logic                        arvalid;
        logic [AxiAddrWidth-1:0]     araddr;
        logic                        rready;
    } axiLiteReqT;

    typedef struct packed {
        logic                        awready;
        logic                        wready;
        logic                        bvalid;
        logic [1:0]                  bresp;
        logic                        arready;
        logic                        rvalid;
        logic [AxiDataWidth-1:0]     rdata;
        logic [1:0]                  rresp;
    } axiLiteRspT;

    // Register map in byte offsets
    localparam logic [AxiAddrWidth-1:0] RegControl = 4'h0;
    localparam logic [AxiAddrWidth-1:0] RegParamLo = 4'h4;
    localparam logic [AxiAddrWidth-1:0] RegParamHi = 4'h8;
    localparam logic [AxiAddrWidth-1:0] RegStatus  = 4'hC;

    // Load start bit in the control register
    localparam int StartBit = 8;

endpackage

//--- hw/configRegisterFile.sv
`timescale 1ns/1ps

module configRegisterFile (
    input  logic                       Clk,
    input  logic                       reset_n,
    input  microrocPkg::axiLiteReqT    axiReq,
    output microrocPkg::axiLiteRspT    axiRsp,
    input  logic [3:0]                 busy,
    input  logic                       selectedDone,
    output microrocPkg::microrocParamT stagedParam,
    output logic [1:0]                 chainSelect,
    output logic                       commitStart
);
    import microrocPkg::*;

    logic [31:0]             paramLo;
    logic [15:0]             paramHi;
    logic                    writeAccept;
    logic                    readAccept;
    logic                    bvalidReg;
    logic                    rvalidReg;
    logic [AxiDataWidth-1:0] rdataReg;
    logic [AxiDataWidth-1:0] readWord;
    logic                    startRequest;

    ////////////////////////////////////////////////////////////
    // Handshakes
    ////////////////////////////////////////////////////////////

    // Both address and data must be present, and no response pending
    assign writeAccept = axiReq.awvalid && axiReq.wvalid && !bvalidReg;
    assign readAccept  = axiReq.arvalid && !rvalidReg;

    always_comb begin
        axiRsp         = '0;
        axiRsp.awready = writeAccept;
        axiRsp.wready  = writeAccept;
        axiRsp.bvalid  = bvalidReg;
        axiRsp.bresp   = RespOkay;
        axiRsp.arready = readAccept;
        axiRsp.rvalid  = rvalidReg;
        axiRsp.rdata   = rdataReg;
        axiRsp.rresp   = RespOkay;
    end

    ////////////////////////////////////////////////////////////
    // Write channel and staging registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            bvalidReg    <= 1'b0;
            paramLo      <= '0;
            paramHi      <= '0;
            chainSelect  <= '0;
            startRequest <= 1'b0;
            commitStart  <= 1'b0;
        end else begin
            // Extra stage so chainSelect has settled before the commit
            startRequest <= 1'b0;
            commitStart  <= startRequest;

            if (writeAccept) begin
                bvalidReg <= 1'b1;
            end else if (axiReq.bready) begin
                bvalidReg <= 1'b0;
            end

            if (writeAccept) begin
                case (axiReq.awaddr)
                    RegControl: begin
                        if (axiReq.wstrb[0]) begin
                            chainSelect <= axiReq.wdata[1:0];
                        end
                        if (axiReq.wstrb[1]) begin
                            startRequest <= axiReq.wdata[StartBit];
                        end
                    end
                    RegParamLo: begin
                        for (int i = 0; i < 4; i++) begin
                            if (axiReq.wstrb[i]) begin
                                paramLo[8*i +: 8] <= axiReq.wdata[8*i +: 8];
                            end
                        end
                    end
                    RegParamHi: begin
                        for (int i = 0; i < 2; i++) begin
                            if (axiReq.wstrb[i]) begin
                                paramHi[8*i +: 8] <= axiReq.wdata[8*i +: 8];
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    assign stagedParam = microrocParamT'({paramHi, paramLo});

    ////////////////////////////////////////////////////////////
    // Read channel
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (axiReq.araddr)
            RegControl: readWord = AxiDataWidth'(chainSelect);
            RegParamLo: readWord = paramLo;
            RegParamHi: readWord = AxiDataWidth'(paramHi);
            RegStatus:  readWord = {24'b0, busy, 3'b0, selectedDone};
            default:    readWord = '0;
        endcase
    end

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            rvalidReg <= 1'b0;
        end else if (readAccept) begin
            rvalidReg <= 1'b1;
        end else if (axiReq.rready) begin
            rvalidReg <= 1'b0;
        end
    end

    // Held until the master takes it
    always_ff @(posedge Clk) begin
        if (readAccept) begin
            rdataReg <= readWord;
        end
    end

endmodule

//--- hw/configParameterDistribution.sv
`timescale 1ns/1ps

module configParameterDistribution #(
    parameter int ChainCount = 4
) (
    input  logic                                        Clk,
    input  logic                                        reset_n,
    input  microrocPkg::microrocParamT                  stagedParam,
    input  logic [1:0]                                  chainSelect,
    input  logic                                        commitStart,
    input  logic [ChainCount-1:0]                       busy,
    input  logic [ChainCount-1:0]                       loadDone,
    output microrocPkg::microrocParamT [ChainCount-1:0] chainParam,
    output logic [ChainCount-1:0]                       loadStart,
    output logic                                        selectedDone
);

    logic chainValid;
    logic chainIdle;

    // Fewer than four chains leaves some select codes unused
    assign chainValid = int'(chainSelect) < ChainCount;

    // A start already issued counts as busy until the shifter reports it
    assign chainIdle = chainValid && !busy[chainSelect] && !loadStart[chainSelect];

    ////////////////////////////////////////////////////////////
    // Per-chain slots and start fan-out
    ////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            chainParam   <= '0;
            loadStart    <= '0;
            selectedDone <= 1'b0;
        end else begin
            loadStart <= '0;

            // Only the selected chain is touched, and only when idle
            if (commitStart && chainIdle) begin
                chainParam[chainSelect] <= stagedParam;
                loadStart[chainSelect]  <= 1'b1;
            end

            if (chainValid) begin
                selectedDone <= loadDone[chainSelect];
            end else begin
                selectedDone <= 1'b0;
            end
        end
    end

endmodule

//--- hw/slowControlShifter.sv
`timescale 1ns/1ps

module slowControlShifter (
    input  logic                       Clk,
    input  logic                       reset_n,
    input  microrocPkg::microrocParamT param,
    input  logic                       loadStart,
    output logic                       serialClock,
    output logic                       serialData,
    output logic                       busy,
    output logic                       loadDone
);
    import microrocPkg::*;

    localparam int CountWidth = $clog2(ParamWidth);

    logic [ParamWidth-1:0] paramBits;
    logic [ParamWidth-1:0] shiftReg;
    logic [CountWidth-1:0] bitCount;
    logic                  startAccept;
    logic                  bitEnd;

    assign paramBits   = param;
    assign startAccept = loadStart && !busy;

    // High phase of the current bit is ending
    assign bitEnd = busy && serialClock;

    ////////////////////////////////////////////////////////////
    // Bit sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            serialClock <= 1'b0;
            serialData  <= 1'b0;
            busy        <= 1'b0;
            loadDone    <= 1'b0;
            bitCount    <= '0;
        end else if (startAccept) begin
            // First bit goes out with the clock low
            serialClock <= 1'b0;
            serialData  <= paramBits[ParamWidth-1];
            busy        <= 1'b1;
            loadDone    <= 1'b0;
            bitCount    <= CountWidth'(ParamWidth - 1);
        end else if (busy) begin
            if (!serialClock) begin
                serialClock <= 1'b1;
            end else if (bitCount == '0) begin
                // Last high phase over
                serialClock <= 1'b0;
                serialData  <= 1'b0;
                busy        <= 1'b0;
                loadDone    <= 1'b1;
            end else begin
                serialClock <= 1'b0;
                serialData  <= shiftReg[ParamWidth-1];
                bitCount    <= bitCount - CountWidth'(1);
            end
        end
    end

    // Holds the bits not yet presented
    always_ff @(posedge Clk) begin
        if (startAccept) begin
            shiftReg <= {paramBits[ParamWidth-2:0], 1'b0};
        end else if (bitEnd) begin
            shiftReg <= {shiftReg[ParamWidth-2:0], 1'b0};
        end
    end

endmodule

//--- hw/microrocConfigTop.sv
`timescale 1ns/1ps

module microrocConfigTop #(
    parameter int ChainCount = microrocPkg::ChainCountDefault
) (
    input  logic                    Clk,
    input  logic                    reset_n,
    input  microrocPkg::axiLiteReqT axiReq,
    output microrocPkg::axiLiteRspT axiRsp,
    output logic [ChainCount-1:0]   scClock,
    output logic [ChainCount-1:0]   scData,
    output logic [ChainCount-1:0]   scDone
);
    import microrocPkg::*;

    microrocParamT                  stagedParam;
    microrocParamT [ChainCount-1:0] chainParam;
    logic [1:0]                     chainSelect;
    logic                           commitStart;
    logic                           selectedDone;
    logic [ChainCount-1:0]          loadStart;
    logic [ChainCount-1:0]          busy;
    logic [3:0]                     busyStatus;

    // Status word always carries four busy bits
    assign busyStatus = 4'(busy);

    configRegisterFile i_configRegisterFile (
        .Clk          (Clk),
        .reset_n      (reset_n),
        .axiReq       (axiReq),
        .axiRsp       (axiRsp),
        .busy         (busyStatus),
        .selectedDone (selectedDone),
        .stagedParam  (stagedParam),
        .chainSelect  (chainSelect),
        .commitStart  (commitStart)
    );

    configParameterDistribution #(
        .ChainCount (ChainCount)
    ) i_configParameterDistribution (
        .Clk          (Clk),
        .reset_n      (reset_n),
        .stagedParam  (stagedParam),
        .chainSelect  (chainSelect),
        .commitStart  (commitStart),
        .busy         (busy),
        .loadDone     (scDone),
        .chainParam   (chainParam),
        .loadStart    (loadStart),
        .selectedDone (selectedDone)
    );

    ////////////////////////////////////////////////////////////
    // One serializer per chain
    ////////////////////////////////////////////////////////////

    for (genvar c = 0; c < ChainCount; c++) begin : g_chain
        slowControlShifter i_slowControlShifter (
            .Clk         (Clk),
            .reset_n     (reset_n),
            .param       (chainParam[c]),
            .loadStart   (loadStart[c]),
            .serialClock (scClock[c]),
            .serialData  (scData[c]),
            .busy        (busy[c]),
            .loadDone    (scDone[c])
        );
    end

endmodule

//--- dv/microrocConfigTb.sv
`timescale 1ns/1ps

module microrocConfigTb;
    import microrocPkg::*;

    localparam int ChainCount  = ChainCountDefault;
    localparam int MaxPatterns = 32;
    localparam int WaitLimit   = 1000;

    logic                  Clk;
    logic                  reset_n;
    axiLiteReqT            axiReq;
    axiLiteRspT            axiRsp;
    logic [ChainCount-1:0] scClock;
    logic [ChainCount-1:0] scData;
    logic [ChainCount-1:0] scDone;

    logic [31:0]           patternMem [0:4*MaxPatterns-1];
    logic [ChainCount-1:0] prevClock;
    logic [ParamWidth-1:0] capturedWord [ChainCount];
    int                    edgeCount [ChainCount];
    logic [ParamWidth-1:0] expectedWord [ChainCount];
    int                    startEdges [ChainCount][ChainCount];
    logic [ChainCount-1:0] pending;
    logic [ChainCount-1:0] solo;
    int                    loadCount;

    microrocConfigTop #(
        .ChainCount (ChainCount)
    ) i_microrocConfigTop (
        .Clk     (Clk),
        .reset_n (reset_n),
        .axiReq  (axiReq),
        .axiRsp  (axiRsp),
        .scClock (scClock),
        .scData  (scData),
        .scDone  (scDone)
    );

    always #4 Clk = ~Clk;

    // Serial monitor samples scData while scClock is high
    always @(negedge Clk) begin
        for (int c = 0; c < ChainCount; c++) begin
            if (!reset_n) begin
                capturedWord[c] <= '0;
                edgeCount[c]    <= 0;
            end else if (scClock[c] && !prevClock[c]) begin
                capturedWord[c] <= {capturedWord[c][ParamWidth-2:0], scData[c]};
                edgeCount[c]    <= edgeCount[c] + 1;
            end
        end
        prevClock <= scClock;
    end

    ////////////////////////////////////////////////////////////
    // Checking and waiting
    ////////////////////////////////////////////////////////////

    task automatic stopOnFailure(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [47:0] actual,
                              input logic [47:0] expected);
        if (actual !== expected) begin
            stopOnFailure($sformatf("ERROR %s: got 0x%0h, expected 0x%0h",
                                    name, actual, expected));
        end
    endtask

    task automatic stepWait(inout int waited, input string what);
        if (waited >= WaitLimit) begin
            stopOnFailure($sformatf("Timed out waiting for %s", what));
        end
        waited++;
        @(negedge Clk);
    endtask

    ////////////////////////////////////////////////////////////
    // AXI4-Lite master
    ////////////////////////////////////////////////////////////

    task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
        int waited;
        @(posedge Clk);
        axiReq.awvalid <= 1'b1;
        axiReq.awaddr  <= addr;
        axiReq.wvalid  <= 1'b1;
        axiReq.wdata   <= data;
        axiReq.wstrb   <= strb;
        waited = 0;
        @(negedge Clk);
        while (!(axiRsp.awready && axiRsp.wready)) begin
            stepWait(waited, "write accept");
        end
        @(posedge Clk);
        axiReq.awvalid <= 1'b0;
        axiReq.wvalid  <= 1'b0;
        axiReq.bready  <= 1'b1;
        waited = 0;
        @(negedge Clk);
        while (!axiRsp.bvalid) begin
            stepWait(waited, "write response");
        end
        checkValue("bresp", 48'(axiRsp.bresp), '0);
        @(posedge Clk);
        axiReq.bready <= 1'b0;
    endtask

    task automatic axiRead(input logic [3:0] addr, output logic [31:0] data);
        int waited;
        @(posedge Clk);
        axiReq.arvalid <= 1'b1;
        axiReq.araddr  <= addr;
        waited = 0;
        @(negedge Clk);
        while (!axiRsp.arready) begin
            stepWait(waited, "read accept");
        end
        @(posedge Clk);
        axiReq.arvalid <= 1'b0;
        axiReq.rready  <= 1'b1;
        waited = 0;
        @(negedge Clk);
        while (!axiRsp.rvalid) begin
            stepWait(waited, "read data");
        end
        checkValue("rresp", 48'(axiRsp.rresp), '0);
        data = axiRsp.rdata;
        @(posedge Clk);
        axiReq.rready <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Loads
    ////////////////////////////////////////////////////////////

    task automatic finishLoad(input logic [1:0] chain);
        logic [31:0] readData;
        int          waited;
        waited = 0;
        @(negedge Clk);
        while (!scDone[chain]) begin
            stepWait(waited, $sformatf("load done on chain %0d", chain));
        end
        checkValue("serial word", capturedWord[chain], expectedWord[chain]);
        axiWrite(RegControl, {30'b0, chain}, 4'h1);
        axiRead(RegStatus, readData);
        checkValue("RegStatus done", 48'(readData[0]), 48'(1));
        checkValue("RegStatus busy", 48'(readData[4 + int'(chain)]), '0);
        checkValue("scDone", 48'(scDone[chain]), 48'(1));
        checkValue("scClock edges", 48'(edgeCount[chain] - startEdges[chain][chain]),
                   48'(ParamWidth));
        // Nothing else ran, so no other chain may have clocked
        if (solo[chain]) begin
            for (int k = 0; k < ChainCount; k++) begin
                if (k != int'(chain)) begin
                    checkValue("idle scClock edges", 48'(edgeCount[k]),
                               48'(startEdges[chain][k]));
                end
            end
        end
        pending[chain] = 1'b0;
    endtask

    task automatic drainLoads();
        for (int c = 0; c < ChainCount; c++) begin
            if (pending[c]) begin
                finishLoad(2'(c));
            end
        end
    endtask

    task automatic runPattern(input logic [1:0] chain, input logic [31:0] hi,
                              input logic [31:0] lo, input logic overlap);
        logic [31:0] readData;
        logic        ignored;
        int          waited;
        if (!overlap) begin
            drainLoads();
        end
        axiWrite(RegParamLo, lo, 4'hf);
        axiRead(RegParamLo, readData);
        checkValue("RegParamLo", 48'(readData), 48'(lo));
        axiWrite(RegParamHi, hi, 4'hf);
        axiRead(RegParamHi, readData);
        checkValue("RegParamHi", 48'(readData), 48'(hi[15:0]));

        // A chain still shifting must drop this start
        ignored = pending[chain];
        axiRead(RegStatus, readData);
        checkValue("RegStatus busy", 48'(readData[4 + int'(chain)]), 48'(ignored));
        if (!ignored) begin
            for (int k = 0; k < ChainCount; k++) begin
                startEdges[chain][k] = edgeCount[k];
            end
            solo &= ~pending;
            solo[chain] = (pending == '0);
            pending[chain] = 1'b1;
            expectedWord[chain] = {hi[15:0], lo};
            loadCount++;
        end

        axiWrite(RegControl, {23'b0, 1'b1, 6'b0, chain}, 4'h3);
        axiRead(RegControl, readData);
        checkValue("RegControl", 48'(readData), 48'(chain));
        if (!ignored) begin
            waited = 0;
            @(negedge Clk);
            while (scDone[chain]) begin
                stepWait(waited, "done to clear on start");
            end
        end
    endtask

    initial begin
        logic [31:0] readData;
        Clk       = 1'b0;
        reset_n   = 1'b0;
        axiReq    = '0;
        pending   = '0;
        solo      = '0;
        loadCount = 0;
        $readmemh("dv/microrocConfigPatterns.hex", patternMem);
        repeat (4) @(posedge Clk);
        reset_n <= 1'b1;

        @(negedge Clk);
        checkValue("scClock", 48'(scClock), '0);
        checkValue("scData", 48'(scData), '0);
        checkValue("scDone", 48'(scDone), '0);
        axiRead(RegStatus, readData);
        checkValue("RegStatus", 48'(readData), '0);

        // Chain code ff ends the list
        for (int i = 0; i < MaxPatterns; i++) begin
            if (patternMem[4*i] == 32'hff) begin
                break;
            end
            runPattern(patternMem[4*i][1:0], patternMem[4*i+1], patternMem[4*i+2],
                       patternMem[4*i+3][0]);
        end
        drainLoads();

        if (loadCount == 0) begin
            stopOnFailure("No load was run from the pattern file");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

//--- dv/microrocConfigPatterns.hex
// chain  paramHi  paramLo  overlap
// overlap 1 issues the load while earlier loads still shift, chain ff ends the list
00 0000abcd 12345678 0
01 0000f00d deadbeef 0
02 00005a5a a5a5a5a5 0
03 0000ffff 00000001 0
// three chains loading at once
00 00001234 89abcdef 0
01 00008001 7ffffffe 1
02 00003c3c c3c3c3c3 1
// second start to a busy chain is dropped
03 00000f0f f0f0f0f0 0
03 0000aaaa 55555555 1
// overlap with a dropped start in the middle
01 0000c001 00c0ffee 0
02 00007777 11112222 1
01 00000000 ffffffff 1
00 00000000 00000000 0
ff 00000000 00000000 0

//--- microrocConfigTop.f
hw/microrocPkg.sv
hw/configRegisterFile.sv
hw/configParameterDistribution.sv
hw/slowControlShifter.sv
hw/microrocConfigTop.sv
dv/microrocConfigTb.sv

//--- Makefile
TB = microrocConfigTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f microrocConfigTop.f --top-module $(TB)

run: build
	@out="$$(./obj_dir/V$(TB))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

lint:
	verilator --lint-only -Wall --timing -f microrocConfigTop.f --top-module microrocConfigTop

clean:
	rm -rf obj_dir
